// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int instr_w    = 16;  // Instruction word
    localparam int data_w     = 16;  // Register and memory word
    localparam int reg_addr_w = 3;   // Eight registers
    localparam int pc_w       = 8;   // Word address into the program
    localparam int opcode_w   = 4;
    localparam int imm_w      = 6;   // Signed, low bits of the word

    ////////////////////
    // Field positions
    ////////////////////
    localparam int rd_lsb  = 9;
    localparam int rs1_lsb = 6;
    localparam int rs2_lsb = 3;

    // Execute operand source
    localparam int fwd_w = 2;
    localparam logic [fwd_w-1:0] fwd_reg = 2'd0;  // Value read in decode
    localparam logic [fwd_w-1:0] fwd_mem = 2'd1;  // ALU result in memory stage
    localparam logic [fwd_w-1:0] fwd_wb  = 2'd2;  // Write-back value

    typedef enum logic [opcode_w-1:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,  // rd = rs1 + rs2
        op_sub  = 4'd2,  // rd = rs1 - rs2
        op_addi = 4'd3,  // rd = rs1 + imm
        op_ld   = 4'd4,  // rd = mem[rs1 + imm]
        op_st   = 4'd5,  // mem[rs1 + imm] = rd
        op_beq  = 4'd6   // pc += imm when rd == rs1
    } opcode_e;

endpackage

`default_nettype wire

// ==== hw/trace_pkg.sv ====
`default_nettype none

package trace_pkg;

    localparam int stamp_w = 16;  // Free-running cycle stamp, wraps
    localparam int tag_w   = 8;   // Fetch order tag, wraps

    // Retire record and counter widths
    localparam int stall_w = 4;   // Saturating stall count
    localparam int flush_w = 16;  // Squashed instruction count

endpackage

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazard_unit
    import cpu_pkg::*;
(
    input  logic [reg_addr_w-1:0] id_rs1,
    input  logic [reg_addr_w-1:0] id_rs2,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  opcode_e               ex_opcode,
    input  logic [reg_addr_w-1:0] mem_rd,
    input  logic                  mem_we_reg,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic                  wb_we,
    input  logic [reg_addr_w-1:0] ex_rs1,
    input  logic [reg_addr_w-1:0] ex_rs2,
    input  logic                  branch_taken,
    output logic                  stall,
    output logic                  flush,
    output logic [fwd_w-1:0]      fwd_a,
    output logic [fwd_w-1:0]      fwd_b
);

    // Load result is not ready until write-back, so hold decode one cycle
    assign stall = (ex_opcode == op_ld) && (ex_rd != '0) &&
                   (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign flush = branch_taken;  // Squash fetch and decode

    ////////////////////
    // Forwarding
    ////////////////////
    always_comb begin
        fwd_a = fwd_reg;
        if (mem_we_reg && mem_rd == ex_rs1) begin
            fwd_a = fwd_mem;  // Youngest producer wins
        end else if (wb_we && wb_rd == ex_rs1) begin
            fwd_a = fwd_wb;
        end
    end

    always_comb begin
        fwd_b = fwd_reg;
        if (mem_we_reg && mem_rd == ex_rs2) begin
            fwd_b = fwd_mem;
        end else if (wb_we && wb_rd == ex_rs2) begin
            fwd_b = fwd_wb;
        end
    end

endmodule

`default_nettype wire

// ==== hw/pipe_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_core
    import cpu_pkg::*, trace_pkg::*;
#(
    parameter int dmem_words = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    output logic [pc_w-1:0]       imem_addr,
    input  logic [instr_w-1:0]    imem_data,
    output logic [reg_addr_w-1:0] id_rs1,
    output logic [reg_addr_w-1:0] id_rs2,
    output logic [reg_addr_w-1:0] ex_rd,
    output opcode_e               ex_opcode,
    output logic [reg_addr_w-1:0] mem_rd,
    output logic                  mem_we_reg,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic                  wb_we,
    output logic [reg_addr_w-1:0] ex_rs1,
    output logic [reg_addr_w-1:0] ex_rs2,
    output logic                  branch_taken,
    input  logic                  stall,
    input  logic                  flush,
    input  logic [fwd_w-1:0]      fwd_a,
    input  logic [fwd_w-1:0]      fwd_b,
    output logic                  fetch_fire,
    output logic [tag_w-1:0]      fetch_tag,
    output logic [tag_w-1:0]      stall_tag,
    output logic                  wb_done,
    output logic [tag_w-1:0]      wb_tag,
    output opcode_e               wb_opcode,
    output logic [data_w-1:0]     wb_data
);

    localparam int dmem_aw = $clog2(dmem_words);

    ////////////////////
    // Fetch
    ////////////////////
    logic                  fetch_en;   // Low for the first cycle out of reset
    logic [pc_w-1:0]       pc;
    logic [tag_w-1:0]      tag_cnt;
    logic [pc_w-1:0]       br_target;

    assign imem_addr  = pc;
    assign fetch_fire = fetch_en & ~stall;
    assign fetch_tag  = tag_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_en <= 1'b0;
            pc       <= '0;
            tag_cnt  <= '0;
        end else begin
            fetch_en <= 1'b1;
            if (flush) begin
                pc <= br_target;
            end else if (fetch_fire) begin
                pc <= pc + 1'b1;
            end
            if (fetch_fire) begin
                tag_cnt <= tag_cnt + 1'b1;  // Squashed fetches use a tag too
            end
        end
    end

    logic                  if_id_valid;
    logic [tag_w-1:0]      if_id_tag;
    logic [pc_w-1:0]       if_id_pc;
    logic [instr_w-1:0]    if_id_instr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_id_valid <= 1'b0;
        end else if (flush) begin
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            if_id_valid <= fetch_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_tag   <= tag_cnt;
            if_id_pc    <= pc;
            if_id_instr <= imem_data;
        end
    end

    ////////////////////
    // Decode
    ////////////////////
    opcode_e               id_op;
    logic [reg_addr_w-1:0] id_rdf;
    logic [reg_addr_w-1:0] id_src1;
    logic [reg_addr_w-1:0] id_src2;
    logic                  id_reg_we;
    logic [data_w-1:0]     id_a;
    logic [data_w-1:0]     id_b;
    logic [data_w-1:0]     regs [1 << reg_addr_w];

    assign id_op  = opcode_e'(if_id_instr[instr_w-1 -: opcode_w]);
    assign id_rdf = if_id_instr[rd_lsb +: reg_addr_w];

    always_comb begin
        id_src1   = '0;
        id_src2   = '0;
        id_reg_we = 1'b0;
        case (id_op)
            op_add, op_sub: begin
                id_src1   = if_id_instr[rs1_lsb +: reg_addr_w];
                id_src2   = if_id_instr[rs2_lsb +: reg_addr_w];
                id_reg_we = 1'b1;
            end
            op_addi, op_ld: begin
                id_src1   = if_id_instr[rs1_lsb +: reg_addr_w];
                id_reg_we = 1'b1;
            end
            op_st, op_beq: begin
                id_src1 = if_id_instr[rs1_lsb +: reg_addr_w];
                id_src2 = id_rdf;  // Store data or compare operand
            end
            default: ;
        endcase
        if (!if_id_valid) begin
            id_src1 = '0;
            id_src2 = '0;
        end
        if (id_rdf == '0) begin
            id_reg_we = 1'b0;  // r0 stays zero
        end
    end

    assign id_rs1 = id_src1;
    assign id_rs2 = id_src2;

    // Write-through covers the producer leaving write-back this cycle
    assign id_a = (id_src1 == '0) ? '0 :
                  (wb_we && wb_rd == id_src1) ? wb_data : regs[id_src1];
    assign id_b = (id_src2 == '0) ? '0 :
                  (wb_we && wb_rd == id_src2) ? wb_data : regs[id_src2];

    logic                  id_ex_valid;
    logic [tag_w-1:0]      id_ex_tag;
    logic [pc_w-1:0]       id_ex_pc;
    opcode_e               id_ex_op;
    logic [reg_addr_w-1:0] id_ex_rd;
    logic                  id_ex_reg_we;
    logic [reg_addr_w-1:0] id_ex_rs1;
    logic [reg_addr_w-1:0] id_ex_rs2;
    logic [data_w-1:0]     id_ex_a;
    logic [data_w-1:0]     id_ex_b;
    logic [imm_w-1:0]      id_ex_imm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex_valid <= 1'b0;
        end else begin
            id_ex_valid <= if_id_valid & ~stall & ~flush;  // Bubble on stall
        end
    end

    always_ff @(posedge clk) begin
        id_ex_tag    <= if_id_tag;
        id_ex_pc     <= if_id_pc;
        id_ex_op     <= id_op;
        id_ex_rd     <= id_rdf;
        id_ex_reg_we <= id_reg_we;
        id_ex_rs1    <= id_src1;
        id_ex_rs2    <= id_src2;
        id_ex_a      <= id_a;
        id_ex_b      <= id_b;
        id_ex_imm    <= if_id_instr[imm_w-1:0];
    end

    ////////////////////
    // Execute
    ////////////////////
    logic [data_w-1:0]     ex_a;
    logic [data_w-1:0]     ex_b;
    logic [data_w-1:0]     ex_imm;
    logic [data_w-1:0]     ex_result;
    logic [data_w-1:0]     ex_mem_result;

    assign ex_rd     = id_ex_rd;
    assign ex_rs1    = id_ex_rs1;
    assign ex_rs2    = id_ex_rs2;
    assign ex_opcode = id_ex_valid ? id_ex_op : op_nop;
    assign ex_imm    = {{(data_w - imm_w){id_ex_imm[imm_w-1]}}, id_ex_imm};

    always_comb begin
        case (fwd_a)
            fwd_mem: ex_a = ex_mem_result;
            fwd_wb:  ex_a = wb_data;
            default: ex_a = id_ex_a;
        endcase
        case (fwd_b)
            fwd_mem: ex_b = ex_mem_result;
            fwd_wb:  ex_b = wb_data;
            default: ex_b = id_ex_b;
        endcase
    end

    always_comb begin
        case (id_ex_op)
            op_add:               ex_result = ex_a + ex_b;
            op_sub:               ex_result = ex_a - ex_b;
            op_addi, op_ld, op_st: ex_result = ex_a + ex_imm;  // Also the address
            default:              ex_result = '0;
        endcase
    end

    assign branch_taken = id_ex_valid && (id_ex_op == op_beq) && (ex_a == ex_b);
    assign br_target    = id_ex_pc + ex_imm[pc_w-1:0];

    logic                  ex_mem_valid;
    logic [tag_w-1:0]      ex_mem_tag;
    opcode_e               ex_mem_op;
    logic [reg_addr_w-1:0] ex_mem_rd;
    logic                  ex_mem_reg_we;
    logic [data_w-1:0]     ex_mem_store;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem_valid <= 1'b0;
        end else begin
            ex_mem_valid <= id_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_tag    <= id_ex_tag;
        ex_mem_op     <= id_ex_op;
        ex_mem_rd     <= id_ex_rd;
        ex_mem_reg_we <= id_ex_reg_we;
        ex_mem_result <= ex_result;
        ex_mem_store  <= ex_b;
    end

    ////////////////////
    // Memory
    ////////////////////
    logic [data_w-1:0]     dmem [dmem_words];
    logic [dmem_aw-1:0]    mem_addr;
    logic [data_w-1:0]     mem_result;

    assign mem_rd     = ex_mem_rd;
    assign mem_we_reg = ex_mem_valid & ex_mem_reg_we;
    assign mem_addr   = ex_mem_result[dmem_aw-1:0];
    assign mem_result = (ex_mem_op == op_ld) ? dmem[mem_addr] : ex_mem_result;

    always_ff @(posedge clk) begin
        if (ex_mem_valid && ex_mem_op == op_st) begin
            dmem[mem_addr] <= ex_mem_store;
        end
    end

    logic                  mem_wb_valid;
    logic [tag_w-1:0]      mem_wb_tag;
    opcode_e               mem_wb_op;
    logic [reg_addr_w-1:0] mem_wb_rd;
    logic                  mem_wb_reg_we;
    logic [data_w-1:0]     mem_wb_result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb_valid <= 1'b0;
        end else begin
            mem_wb_valid <= ex_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_tag    <= ex_mem_tag;
        mem_wb_op     <= ex_mem_op;
        mem_wb_rd     <= ex_mem_rd;
        mem_wb_reg_we <= ex_mem_reg_we;
        mem_wb_result <= mem_result;
    end

    ////////////////////
    // Write-back
    ////////////////////
    assign wb_done   = mem_wb_valid;
    assign wb_we     = mem_wb_valid & mem_wb_reg_we;
    assign wb_rd     = mem_wb_rd;
    assign wb_data   = mem_wb_result;
    assign wb_tag    = mem_wb_tag;
    assign wb_opcode = mem_wb_op;
    assign stall_tag = if_id_tag;  // Decode holds the stalled one

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/trace_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module trace_unit
    import cpu_pkg::*, trace_pkg::*;
#(
    parameter int trace_depth = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_fire,
    input  logic [tag_w-1:0]   fetch_tag,
    input  logic               stall,
    input  logic [tag_w-1:0]   stall_tag,
    input  logic               flush,
    input  logic               wb_done,
    input  logic [tag_w-1:0]   wb_tag,
    input  opcode_e            wb_opcode,
    output logic               ret_valid,
    output logic [tag_w-1:0]   ret_tag,
    output opcode_e            ret_opcode,
    output logic [stamp_w-1:0] ret_fetch_stamp,
    output logic [stamp_w-1:0] ret_latency,
    output logic [stall_w-1:0] ret_stalls,
    output logic [flush_w-1:0] flush_count
);

    localparam int idx_w = $clog2(trace_depth);

    logic [stamp_w-1:0] cycle;                     // Free-running, wraps
    logic [stamp_w-1:0] stamp_tbl [trace_depth];   // Fetch cycle per tag
    logic [stall_w-1:0] stall_tbl [trace_depth];   // Stall cycles per tag
    logic [idx_w-1:0]   fetch_idx;
    logic [idx_w-1:0]   stall_idx;
    logic [idx_w-1:0]   wb_idx;

    assign fetch_idx = fetch_tag[idx_w-1:0];
    assign stall_idx = stall_tag[idx_w-1:0];
    assign wb_idx    = wb_tag[idx_w-1:0];

    ////////////////////
    // Stamp table
    ////////////////////
    // Fetch and stall never fire in the same cycle
    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            stamp_tbl[fetch_idx] <= cycle;
            stall_tbl[fetch_idx] <= '0;
        end else if (stall && stall_tbl[stall_idx] != '1) begin
            stall_tbl[stall_idx] <= stall_tbl[stall_idx] + 1'b1;  // Saturates
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle       <= '0;
            ret_valid   <= 1'b0;
            flush_count <= '0;
        end else begin
            cycle     <= cycle + 1'b1;
            ret_valid <= wb_done;
            if (flush) begin
                flush_count <= flush_count + flush_w'(2);  // Fetch and decode
            end
        end
    end

    ////////////////////
    // Retire record
    ////////////////////
    always_ff @(posedge clk) begin
        if (wb_done) begin
            ret_tag         <= wb_tag;
            ret_opcode      <= wb_opcode;
            ret_fetch_stamp <= stamp_tbl[wb_idx];
            ret_latency     <= cycle - stamp_tbl[wb_idx];  // Wraps with the stamp
            ret_stalls      <= stall_tbl[wb_idx];
        end
    end

endmodule

`default_nettype wire

// ==== hw/pipe_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_top
    import cpu_pkg::*, trace_pkg::*;
#(
    parameter int trace_depth = 8,   // Above the five in flight
    parameter int dmem_words  = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    output logic [pc_w-1:0]       imem_addr,
    input  logic [instr_w-1:0]    imem_data,
    output logic                  wb_we,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [data_w-1:0]     wb_data,
    output logic                  ret_valid,
    output logic [tag_w-1:0]      ret_tag,
    output opcode_e               ret_opcode,
    output logic [stamp_w-1:0]    ret_fetch_stamp,
    output logic [stamp_w-1:0]    ret_latency,
    output logic [stall_w-1:0]    ret_stalls,
    output logic [flush_w-1:0]    flush_count
);

    // Core to hazard unit
    logic [reg_addr_w-1:0] id_rs1;
    logic [reg_addr_w-1:0] id_rs2;
    logic [reg_addr_w-1:0] ex_rd;
    opcode_e               ex_opcode;
    logic [reg_addr_w-1:0] mem_rd;
    logic                  mem_we_reg;
    logic [reg_addr_w-1:0] ex_rs1;
    logic [reg_addr_w-1:0] ex_rs2;
    logic                  branch_taken;
    logic                  stall;
    logic                  flush;
    logic [fwd_w-1:0]      fwd_a;
    logic [fwd_w-1:0]      fwd_b;

    // Core to trace unit
    logic                  fetch_fire;
    logic [tag_w-1:0]      fetch_tag;
    logic [tag_w-1:0]      stall_tag;
    logic                  wb_done;
    logic [tag_w-1:0]      wb_tag;
    opcode_e               wb_opcode;

    pipe_core #(
        .dmem_words(dmem_words)
    ) u_core (
        .clk,
        .rst,
        .imem_addr,
        .imem_data,
        .id_rs1,
        .id_rs2,
        .ex_rd,
        .ex_opcode,
        .mem_rd,
        .mem_we_reg,
        .wb_rd,
        .wb_we,
        .ex_rs1,
        .ex_rs2,
        .branch_taken,
        .stall,
        .flush,
        .fwd_a,
        .fwd_b,
        .fetch_fire,
        .fetch_tag,
        .stall_tag,
        .wb_done,
        .wb_tag,
        .wb_opcode,
        .wb_data
    );

    hazard_unit u_hazard (
        .id_rs1,
        .id_rs2,
        .ex_rd,
        .ex_opcode,
        .mem_rd,
        .mem_we_reg,
        .wb_rd,
        .wb_we,
        .ex_rs1,
        .ex_rs2,
        .branch_taken,
        .stall,
        .flush,
        .fwd_a,
        .fwd_b
    );

    trace_unit #(
        .trace_depth(trace_depth)
    ) u_trace (
        .clk,
        .rst,
        .fetch_fire,
        .fetch_tag,
        .stall,
        .stall_tag,
        .flush,
        .wb_done,
        .wb_tag,
        .wb_opcode,
        .ret_valid,
        .ret_tag,
        .ret_opcode,
        .ret_fetch_stamp,
        .ret_latency,
        .ret_stalls,
        .flush_count
    );

endmodule

`default_nettype wire

// ==== dv/pipe_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_asserts
    import cpu_pkg::*, trace_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  wb_we,
    input logic [reg_addr_w-1:0] wb_rd,
    input logic                  wb_done,
    input logic                  flush,
    input logic                  ret_valid,
    input logic [tag_w-1:0]      ret_tag,
    input logic [stamp_w-1:0]    ret_latency,
    input logic [stall_w-1:0]    ret_stalls,
    input logic [flush_w-1:0]    flush_count
);

    int unsigned fail_count = 0;  // Failed assertions so far

    logic [tag_w-1:0] last_tag;   // Tag of the previous retire
    logic             tag_seen;
    logic [tag_w-1:0] tag_step;

    assign tag_step = ret_tag - last_tag;  // Wraps with the tag

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tag_seen <= 1'b0;
            last_tag <= '0;
        end else if (ret_valid) begin
            tag_seen <= 1'b1;
            last_tag <= ret_tag;
        end
    end

    ////////////////////
    // Reset behavior
    ////////////////////
    a_reset_quiet: assert property (@(posedge clk)
        rst |-> (!wb_we && !ret_valid && flush_count == '0))
        else begin fail_count++; $error("outputs active during reset"); end

    a_release_quiet: assert property (@(posedge clk)
        $fell(rst) |-> (!wb_we && !ret_valid && flush_count == '0))
        else begin fail_count++; $error("outputs active right after reset"); end

    ////////////////////
    // Retire records
    ////////////////////
    a_latency: assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> ret_latency == stamp_w'(4 + ret_stalls))
        else begin fail_count++; $error("latency differs from four plus stalls"); end

    a_tag_order: assert property (@(posedge clk) disable iff (rst)
        (ret_valid && tag_seen) |-> (tag_step != '0 && tag_step < tag_w'(128)))
        else begin fail_count++; $error("retire tag did not increase"); end

    a_wb_retires: assert property (@(posedge clk) disable iff (rst)
        wb_done |=> ret_valid)
        else begin fail_count++; $error("write-back without a retire record"); end

    a_wb_rd: assert property (@(posedge clk) disable iff (rst)
        wb_we |-> wb_rd != '0)
        else begin fail_count++; $error("write-back to register zero"); end

    // Two squashed per taken branch, nothing otherwise
    a_flush_step: assert property (@(posedge clk) disable iff (rst)
        flush |=> flush_count == flush_w'($past(flush_count) + 2))
        else begin fail_count++; $error("flush count did not rise by two"); end

    a_flush_hold: assert property (@(posedge clk) disable iff (rst)
        !flush |=> flush_count == $past(flush_count))
        else begin fail_count++; $error("flush count moved without a flush"); end

endmodule

bind pipe_top pipe_asserts u_asserts (.*);

`default_nettype wire

// ==== dv/pipe_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_tb
    import cpu_pkg::*, trace_pkg::*;
();

    localparam int prog_len       = 15;        // Last program word is a NOP
    localparam int rom_words      = 1 << pc_w;
    localparam int dmem_words     = 16;
    localparam int retire_timeout = 200;       // Cycles

    logic                  clk;
    logic                  rst;
    logic [pc_w-1:0]       imem_addr;
    logic [instr_w-1:0]    imem_data;
    logic                  wb_we;
    logic [reg_addr_w-1:0] wb_rd;
    logic [data_w-1:0]     wb_data;
    logic                  ret_valid;
    logic [tag_w-1:0]      ret_tag;
    opcode_e               ret_opcode;
    logic [stamp_w-1:0]    ret_fetch_stamp;
    logic [stamp_w-1:0]    ret_latency;
    logic [stall_w-1:0]    ret_stalls;
    logic [flush_w-1:0]    flush_count;

    logic [instr_w-1:0]    rom [rom_words];

    // Expected results from the ISA model
    logic [reg_addr_w-1:0] exp_rd [$];
    logic [data_w-1:0]     exp_data [$];
    logic [tag_w-1:0]      exp_tag [$];
    opcode_e               exp_op [$];
    logic [stall_w-1:0]    exp_stalls [$];
    int                    taken_count = 0;
    int                    retire_count = 0;

    // Fetch stamps are checked against the edge count
    int                    cycle_count = 0;      // Rising edges so far
    logic [stamp_w-1:0]    stamp_base;           // Stamp counter value at edge zero
    bit                    stamp_base_known = 1'b0;
    logic [stamp_w-1:0]    exp_fetch;

    pipe_top #(
        .trace_depth(8),
        .dmem_words(dmem_words)
    ) dut_i (
        .clk,
        .rst,
        .imem_addr,
        .imem_data,
        .wb_we,
        .wb_rd,
        .wb_data,
        .ret_valid,
        .ret_tag,
        .ret_opcode,
        .ret_fetch_stamp,
        .ret_latency,
        .ret_stalls,
        .flush_count
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Instruction ROM answers the PC shortly after each edge
    initial begin
        imem_data = '0;
        forever begin
            @(posedge clk);
            #1 imem_data = rom[imem_addr];
        end
    end

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic abort_run(string reason);
        $display("Error at %0t: %s", $time, reason);
        stop_run();
    endtask

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("Fail at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        stop_run();
    endtask

    function automatic logic [instr_w-1:0] encode(opcode_e op, int rd, int rs1, int low);
        return {op, reg_addr_w'(rd), reg_addr_w'(rs1), imm_w'(low)};
    endfunction

    ////////////////////
    // Program
    ////////////////////
    task automatic build_program(logic [imm_w-1:0] imm_a, logic [imm_w-1:0] imm_b);
        for (int a = 0; a < rom_words; a++) begin
            rom[a] = {op_nop, 4'h0, pc_w'(a)};  // Trailing NOPs carry their address
        end
        rom[0]  = encode(op_addi, 1, 0, imm_a);
        rom[1]  = encode(op_addi, 2, 0, imm_b);
        rom[2]  = encode(op_add,  3, 1, 2 << 3);  // Forward from memory and write-back
        rom[3]  = encode(op_sub,  4, 3, 1 << 3);  // r4 ends up equal to r2
        rom[4]  = encode(op_st,   3, 0, 5);
        rom[5]  = encode(op_ld,   5, 0, 5);
        rom[6]  = encode(op_add,  6, 5, 1 << 3);  // Load-use
        rom[7]  = encode(op_beq,  5, 3, 3);       // Taken, to word 10
        rom[8]  = encode(op_addi, 7, 0, 1);       // Squashed
        rom[9]  = encode(op_addi, 7, 0, 2);       // Squashed
        rom[10] = encode(op_beq,  1, 4, 2);       // Not taken, r1 differs from r2
        rom[11] = encode(op_addi, 7, 6, -3);
        rom[12] = encode(op_sub,  7, 7, 2 << 3);
        rom[13] = encode(op_addi, 0, 1, 7);       // Targets r0, no write
    endtask

    // Runs the program in order and lists the writes and retires it implies
    function automatic void run_reference();
        logic [data_w-1:0]  r [1 << reg_addr_w];
        logic [data_w-1:0]  m [dmem_words];
        logic [pc_w-1:0]    pc;
        logic [pc_w-1:0]    next_pc;
        logic [tag_w-1:0]   tag;
        logic [instr_w-1:0] ins;
        logic [data_w-1:0]  imm;
        logic [data_w-1:0]  addr;
        logic [data_w-1:0]  res;
        opcode_e            op;
        int                 rd;
        int                 rs1;
        int                 src1;
        int                 src2;
        int                 prev_rd;
        int                 steps;
        bit                 prev_ld;
        bit                 we;
        for (int i = 0; i < (1 << reg_addr_w); i++) r[i] = '0;
        for (int i = 0; i < dmem_words; i++) m[i] = '0;
        pc      = '0;
        tag     = '0;
        prev_ld = 1'b0;
        prev_rd = 0;
        steps   = 0;
        while (pc < prog_len && steps < 64) begin
            ins  = rom[pc];
            op   = opcode_e'(ins[instr_w-1 -: opcode_w]);
            rd   = ins[rd_lsb +: reg_addr_w];
            rs1  = ins[rs1_lsb +: reg_addr_w];
            imm  = {{(data_w - imm_w){ins[imm_w-1]}}, ins[imm_w-1:0]};
            addr = r[rs1] + imm;
            src1 = (op == op_nop) ? 0 : rs1;
            src2 = (op == op_add || op == op_sub) ? int'(ins[rs2_lsb +: reg_addr_w]) :
                   (op == op_st || op == op_beq) ? rd : 0;
            exp_tag.push_back(tag);
            exp_op.push_back(op);
            exp_stalls.push_back((prev_ld && prev_rd != 0 &&
                                  (src1 == prev_rd || src2 == prev_rd)) ? 1 : 0);
            we      = 1'b0;
            res     = '0;
            next_pc = pc + 1'b1;
            case (op)
                op_add: begin
                    res = r[rs1] + r[src2];
                    we  = 1'b1;
                end
                op_sub: begin
                    res = r[rs1] - r[src2];
                    we  = 1'b1;
                end
                op_addi: begin
                    res = addr;
                    we  = 1'b1;
                end
                op_ld: begin
                    res = m[addr % dmem_words];
                    we  = 1'b1;
                end
                op_st:   m[addr % dmem_words] = r[rd];
                op_beq: begin
                    if (r[rd] == r[rs1]) begin
                        next_pc = pc + imm[pc_w-1:0];
                        tag     = tag + 2;  // Fetch and decode squashed
                        taken_count++;
                    end
                end
                default: ;
            endcase
            if (we && rd != 0) begin
                r[rd] = res;
                exp_rd.push_back(reg_addr_w'(rd));
                exp_data.push_back(res);
            end
            prev_ld = (op == op_ld);
            prev_rd = rd;
            tag     = tag + 1'b1;
            pc      = next_pc;
            steps++;
        end
    endfunction

    ////////////////////
    // Output checks
    ////////////////////
    always @(negedge clk) begin
        if (dut_i.u_asserts.fail_count != 0) begin
            abort_run("a bound assertion failed");
        end
        if (!rst && wb_we) begin
            if (exp_rd.size() == 0) begin
                abort_run("register write after the program's last write");
            end
            assert (wb_rd == exp_rd[0]) else report_mismatch("wb_rd", exp_rd[0], wb_rd);
            assert (wb_data == exp_data[0])
                else report_mismatch("wb_data", exp_data[0], wb_data);
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
        end
        if (!rst && ret_valid) begin
            if (retire_count < exp_tag.size()) begin
                assert (ret_tag == exp_tag[retire_count])
                    else report_mismatch("ret_tag", exp_tag[retire_count], ret_tag);
                assert (ret_opcode == exp_op[retire_count])
                    else report_mismatch("ret_opcode", exp_op[retire_count], ret_opcode);
                assert (ret_stalls == exp_stalls[retire_count])
                    else report_mismatch("ret_stalls", exp_stalls[retire_count], ret_stalls);
                // Fetch was five cycles plus stalls before the record
                exp_fetch = stamp_w'(cycle_count - 5 - int'(exp_stalls[retire_count]));
                if (!stamp_base_known) begin
                    stamp_base       = ret_fetch_stamp - exp_fetch;  // Counter origin is free
                    stamp_base_known = 1'b1;
                end
                assert (ret_fetch_stamp == stamp_w'(exp_fetch + stamp_base))
                    else report_mismatch("ret_fetch_stamp", stamp_w'(exp_fetch + stamp_base),
                                         ret_fetch_stamp);
            end
            retire_count++;
        end
    end

    initial begin
        logic [imm_w-1:0] imm_a;
        logic [imm_w-1:0] imm_b;
        int               waited;
        rst = 1'b1;
        void'($urandom(32'h3508920e));
        imm_a = imm_w'($urandom);
        do begin
            imm_b = imm_w'($urandom);
        end while (imm_b == imm_a);  // Keeps the second BEQ not taken
        build_program(imm_a, imm_b);
        run_reference();
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        waited = 0;
        while (retire_count < exp_tag.size() && waited < retire_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (retire_count < exp_tag.size()) begin
            abort_run("timeout waiting for the program to retire");
        end
        assert (flush_count == flush_w'(2 * taken_count))
            else report_mismatch("flush_count", 2 * taken_count, flush_count);
        assert (exp_rd.size() == 0) else abort_run("expected register writes never happened");
        if (dut_i.u_asserts.fail_count != 0) begin
            abort_run("a bound assertion failed");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/cpu_pkg.sv
hw/trace_pkg.sv
hw/hazard_unit.sv
hw/pipe_core.sv
hw/trace_unit.sv
hw/pipe_top.sv
dv/pipe_asserts.sv
dv/pipe_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pipe_tb -f compile.f
./obj_dir/Vpipe_tb 2>&1 | tee sim.log

if grep -q "sim passed" sim.log; then
    echo "Result: PASS"
    exit 0
fi
echo "Result: FAIL"
exit 1
